/* dv/dma_ctrl_checker.sv */
// ######################################################################
// checker: descriptor and irq monitor, value compare, result counts
// ######################################################################

module dma_ctrl_checker (
    input logic                    clk,
    input logic                    rst,
    input dma_desc_pkg::dma_desc_t desc,
    input logic                    desc_valid,
    input logic                    desc_ready,
    input logic                    status_valid,
    input logic                    irq,
    input logic                    exp_irq_en
);

    dma_desc_pkg::dma_desc_t exp_q[$];
    int tests = 0;
    int errors = 0;
    int desc_seen = 0;

    task automatic compare(input string name, input logic [71:0] exp, input logic [71:0] act);
        tests++;
        if (exp === act) begin
            $display("PASS %s expected %h actual %h", name, exp, act);
        end else begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %s", msg);
    endtask

    // every transfer is matched in order against the expected queue
    always @(posedge clk) begin
        if (!rst && desc_valid && desc_ready) begin
            if (exp_q.size() == 0) begin
                report_error("a descriptor was issued when none was expected");
            end else begin
                compare($sformatf("desc_%0d", desc_seen), exp_q.pop_front(), desc);
            end
            desc_seen++;
        end
    end

    // irq follows status_valid only while enabled
    always @(posedge clk) begin
        if (!rst && irq !== (status_valid && exp_irq_en)) begin
            report_error($sformatf("irq is %b with status_valid %b and irq_en %b",
                                   irq, status_valid, exp_irq_en));
        end
    end

endmodule

/* dv/dma_ctrl_sva.sv */
// ######################################################################
// handshake assertions, bound to the controller top
// ######################################################################

module dma_ctrl_sva (
    input logic                    clk,
    input logic                    rst,
    input dma_desc_pkg::dma_desc_t desc,
    input logic                    desc_valid,
    input logic                    desc_ready,
    input logic                    req_valid,
    input logic                    req_ready,
    input logic                    resp_valid,
    input logic                    resp_ready,
    input logic                    status_valid,
    input logic                    irq
);

    a_desc_stable: assert property (@(posedge clk) disable iff (rst)
        desc_valid && !desc_ready |=> desc_valid && $stable(desc))
        else $error("desc changed while stalled");

    a_resp_held: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid)
        else $error("resp_valid dropped before resp_ready");

    a_no_accept: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !(req_valid && req_ready))
        else $error("request accepted with a response pending");

    a_irq_status: assert property (@(posedge clk) disable iff (rst)
        irq |-> status_valid)
        else $error("irq without status_valid");

endmodule

bind dma_ctrl_top dma_ctrl_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .desc         (desc),
    .desc_valid   (desc_valid),
    .desc_ready   (desc_ready),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .status_valid (status_valid),
    .irq          (irq)
);

/* dv/dma_ctrl_tb.sv */
// ######################################################################
// testbench: clock, reset, stimulus table, status responder, watchdog
// ######################################################################

module dma_ctrl_tb;

    typedef enum {WR, RD, SINGLE, RUN, HOLD, WAIT} kind_e;
    typedef struct {
        string       name;
        kind_e       kind;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } row_t;

    logic                    clk = 1'b0;
    logic                    rst = 1'b1;
    dma_regs_pkg::reg_req_t  req = '0;
    logic                    req_valid = 1'b0;
    logic                    req_ready;
    logic [31:0]             resp_data;
    logic                    resp_valid;
    logic                    resp_ready = 1'b1;
    dma_desc_pkg::dma_desc_t desc;
    logic                    desc_valid;
    logic                    desc_ready = 1'b0;
    dma_desc_pkg::dma_status_t status = '0;
    logic                    status_valid = 1'b0;
    logic                    irq;
    logic                    exp_irq_en = 1'b0;
    logic                    hold = 1'b0;
    logic [7:0]              tag_q[$];
    logic [31:0]             shadow[int];
    row_t                    rows[$];

    dma_ctrl_top u_dma_ctrl_top (.*);

    dma_ctrl_checker u_chk (
        .clk          (clk),
        .rst          (rst),
        .desc         (desc),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .status_valid (status_valid),
        .irq          (irq),
        .exp_irq_en   (exp_irq_en)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic add_row(input string n, input kind_e k, input logic [15:0] a,
                           input logic [31:0] d, input logic [31:0] e);
        row_t r;
        r.name = n;
        r.kind = k;
        r.addr = a;
        r.data = d;
        r.exp  = e;
        rows.push_back(r);
    endtask

    task automatic reg_access(input logic w, input logic [15:0] a, input logic [31:0] d,
                              output logic [31:0] r);
        logic taken;
        @(negedge clk);
        req.write = w;
        req.addr  = a;
        req.wdata = d;
        req_valid = 1'b1;
        // request held until an edge with req_ready high
        do begin
            taken = req_ready;
            @(negedge clk);
        end while (!taken);
        req_valid = 1'b0;
        if (!resp_valid) u_chk.report_error("no response one cycle after a request");
        r = resp_data;
        if (w) begin
            shadow[a] = d;
            if (a == dma_regs_pkg::REG_IRQ_EN) exp_irq_en = d[0];
        end
    endtask

    // expected descriptors from the programmed block config
    task automatic block_run(input row_t r);
        dma_desc_pkg::dma_desc_t e;
        logic [31:0] dummy;
        logic [31:0] rd_offset;
        logic [15:0] roff;
        for (int k = 0; k < r.data; k++) begin
            e.dma_addr = shadow[dma_regs_pkg::REG_BLK_DMA_BASE]
                + ((shadow[dma_regs_pkg::REG_BLK_DMA_OFFSET]
                    + k * shadow[dma_regs_pkg::REG_BLK_DMA_STRIDE])
                   & shadow[dma_regs_pkg::REG_BLK_DMA_MASK]);
            roff = shadow[dma_regs_pkg::REG_BLK_RAM_OFFSET]
                + k * shadow[dma_regs_pkg::REG_BLK_RAM_STRIDE];
            e.ram_addr = shadow[dma_regs_pkg::REG_BLK_RAM_BASE]
                + (roff & shadow[dma_regs_pkg::REG_BLK_RAM_MASK]);
            e.len = shadow[dma_regs_pkg::REG_BLK_LEN];
            e.tag = r.data - k;
            u_chk.exp_q.push_back(e);
        end
        reg_access(1'b1, dma_regs_pkg::REG_BLK_COUNT, r.data, dummy);
        reg_access(1'b1, dma_regs_pkg::REG_BLK_RUN, 32'd1, dummy);
        while (u_chk.exp_q.size() != 0) @(negedge clk);
        shadow[dma_regs_pkg::REG_BLK_DMA_OFFSET] +=
            r.data * shadow[dma_regs_pkg::REG_BLK_DMA_STRIDE];
        shadow[dma_regs_pkg::REG_BLK_RAM_OFFSET] +=
            r.data * shadow[dma_regs_pkg::REG_BLK_RAM_STRIDE];
        // offset has stepped once per issued descriptor
        reg_access(1'b0, dma_regs_pkg::REG_BLK_DMA_OFFSET, 0, rd_offset);
        u_chk.compare(r.name, shadow[dma_regs_pkg::REG_BLK_DMA_OFFSET], rd_offset);
    endtask

    // one status per transfer, in order, after 1 to 5 cycles
    always @(posedge clk) begin
        if (!rst && desc_valid && desc_ready) tag_q.push_back(desc.tag);
    end

    initial begin
        logic [7:0] t;
        forever begin
            @(negedge clk);
            status_valid = 1'b0;
            if (!hold && tag_q.size() > 0) begin
                repeat ($urandom_range(0, 4)) @(negedge clk);
                t = tag_q.pop_front();
                status.tag   = t;
                status.error = t[3:0];
                status_valid = 1'b1;
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            desc_ready = $urandom_range(0, 1);
            resp_ready = $urandom_range(0, 1);
        end
    end

    initial begin
        #1;
        #(rows.size() * 300 * 8);
        $display("timeout: the table did not finish in time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        void'($urandom(32'h820e));
        add_row("irq_en_on", WR, dma_regs_pkg::REG_IRQ_EN, 1, 0);
        add_row("blk_len", WR, dma_regs_pkg::REG_BLK_LEN, 32'h40, 0);
        add_row("dma_base", WR, dma_regs_pkg::REG_BLK_DMA_BASE, 32'h8000_0000, 0);
        add_row("dma_offset", WR, dma_regs_pkg::REG_BLK_DMA_OFFSET, 32'h30, 0);
        add_row("dma_mask", WR, dma_regs_pkg::REG_BLK_DMA_MASK, 32'hff, 0);
        add_row("dma_stride", WR, dma_regs_pkg::REG_BLK_DMA_STRIDE, 32'h50, 0);
        add_row("ram_base", WR, dma_regs_pkg::REG_BLK_RAM_BASE, 32'h1000, 0);
        add_row("ram_offset", WR, dma_regs_pkg::REG_BLK_RAM_OFFSET, 32'h8, 0);
        add_row("ram_mask", WR, dma_regs_pkg::REG_BLK_RAM_MASK, 32'h3f, 0);
        add_row("ram_stride", WR, dma_regs_pkg::REG_BLK_RAM_STRIDE, 32'h18, 0);
        add_row("rd_dma_base", RD, dma_regs_pkg::REG_BLK_DMA_BASE, 0, 32'h8000_0000);
        add_row("rd_dma_mask", RD, dma_regs_pkg::REG_BLK_DMA_MASK, 0, 32'hff);
        add_row("rd_ram_stride", RD, dma_regs_pkg::REG_BLK_RAM_STRIDE, 0, 32'h18);
        add_row("rd_unmapped", RD, 16'h0004, 0, 0);
        add_row("single_dma", WR, dma_regs_pkg::REG_DESC_DMA_ADDR, 32'h1234_5670, 0);
        add_row("single_ram", WR, dma_regs_pkg::REG_DESC_RAM_ADDR, 32'h0abc, 0);
        add_row("single_len", WR, dma_regs_pkg::REG_DESC_LEN, 32'h200, 0);
        add_row("single_launch", SINGLE, dma_regs_pkg::REG_DESC_TAG, 32'h5a, 0);
        add_row("single_done", WAIT, dma_regs_pkg::REG_ACTIVE, 0, 0);
        add_row("status_first", RD, dma_regs_pkg::REG_DESC_STATUS, 0, 32'h8a00_005a);
        add_row("status_second", RD, dma_regs_pkg::REG_DESC_STATUS, 0, 32'h0a00_005a);
        add_row("block_run", RUN, 0, 5, 0);
        add_row("block_done", WAIT, dma_regs_pkg::REG_BLK_RUN, 0, 0);
        add_row("irq_en_off", WR, dma_regs_pkg::REG_IRQ_EN, 0, 0);
        add_row("hold_on", HOLD, 0, 1, 0);
        add_row("held_run", RUN, 0, 5, 0);
        add_row("held_active", RD, dma_regs_pkg::REG_ACTIVE, 0, 5);
        add_row("held_busy", RD, dma_regs_pkg::REG_BLK_RUN, 0, 1);
        add_row("hold_off", HOLD, 0, 0, 0);
        add_row("held_done", WAIT, dma_regs_pkg::REG_BLK_RUN, 0, 0);
        add_row("final_active", RD, dma_regs_pkg::REG_ACTIVE, 0, 0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        u_chk.compare("reset_outputs", 72'h1,
                      72'({desc_valid, resp_valid, irq, req_ready}));
        foreach (rows[i]) begin
            case (rows[i].kind)
                WR: begin
                    reg_access(1'b1, rows[i].addr, rows[i].data, r);
                    u_chk.compare(rows[i].name, rows[i].exp, r);
                end
                RD: begin
                    reg_access(1'b0, rows[i].addr, 0, r);
                    u_chk.compare(rows[i].name, rows[i].exp, r);
                end
                SINGLE: begin
                    u_chk.exp_q.push_back({shadow[dma_regs_pkg::REG_DESC_DMA_ADDR],
                        shadow[dma_regs_pkg::REG_DESC_RAM_ADDR][15:0],
                        shadow[dma_regs_pkg::REG_DESC_LEN][15:0], rows[i].data[7:0]});
                    reg_access(1'b1, rows[i].addr, rows[i].data, r);
                    // descriptor must leave before its status can be awaited
                    while (u_chk.exp_q.size() != 0) @(negedge clk);
                    u_chk.compare(rows[i].name, rows[i].exp, r);
                end
                RUN: block_run(rows[i]);
                HOLD: hold = rows[i].data[0];
                WAIT: begin
                    reg_access(1'b0, rows[i].addr, 0, r);
                    // poll until the value appears, at most 50 reads
                    for (int n = 1; n < 50 && r != rows[i].exp; n++) begin
                        reg_access(1'b0, rows[i].addr, 0, r);
                    end
                    u_chk.compare(rows[i].name, rows[i].exp, r);
                end
                default: ;
            endcase
        end
        repeat (10) @(negedge clk);
        $display("tests %0d, errors %0d", u_chk.tests, u_chk.errors);
        if (u_chk.errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* rtl/dma_block_engine.sv */
// ###################################################################
// single and block descriptor issue, stride and mask address stepping
// ###################################################################

module dma_block_engine (
    input  logic                           clk,
    input  logic                           rst,
    input  dma_regs_pkg::reg_op_t          op,
    input  dma_regs_pkg::blk_cfg_t         cfg,
    input  dma_desc_pkg::dma_desc_t        single_desc,
    input  logic [dma_desc_pkg::CNT_W-1:0] active_count,
    output dma_desc_pkg::dma_desc_t        desc,
    output logic                           desc_valid,
    input  logic                           desc_ready,
    output dma_regs_pkg::blk_view_t        blk
);

    dma_desc_pkg::blk_state_e            state;
    logic                                run;
    logic [dma_desc_pkg::CNT_W-1:0]      count;
    logic [dma_desc_pkg::DMA_ADDR_W-1:0] dma_offset;
    logic [dma_desc_pkg::RAM_ADDR_W-1:0] ram_offset;
    logic                                wr;
    logic                                launch;
    logic                                issue;
    dma_desc_pkg::dma_desc_t             next_desc;

    assign wr     = op.valid && op.write;
    assign launch = wr && op.reg_addr == dma_regs_pkg::REG_DESC_TAG;
    // output slot empty or draining this cycle
    assign issue  = state == dma_desc_pkg::BLK_ISSUE && count != '0
                    && (!desc_valid || desc_ready);

    always_comb begin
        next_desc.dma_addr = cfg.dma_base + (dma_offset & cfg.dma_mask);
        next_desc.ram_addr = cfg.ram_base + (ram_offset & cfg.ram_mask);
        next_desc.len      = cfg.len;
        next_desc.tag      = count[dma_desc_pkg::TAG_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= dma_desc_pkg::BLK_IDLE;
            run        <= 1'b0;
            count      <= '0;
            desc_valid <= 1'b0;
        end else begin
            desc_valid <= (desc_valid && !desc_ready) || launch || issue;
            if (issue) begin
                count <= count - 1'b1;
            end
            case (state)
                dma_desc_pkg::BLK_ISSUE: begin
                    if (count == '0) begin
                        state <= dma_desc_pkg::BLK_DRAIN;
                    end
                end
                dma_desc_pkg::BLK_DRAIN: begin
                    // last descriptor gone and every status back
                    if (!desc_valid && active_count == '0) begin
                        state <= dma_desc_pkg::BLK_IDLE;
                        run   <= 1'b0;
                    end
                end
                default: ;
            endcase
            if (wr && op.reg_addr == dma_regs_pkg::REG_BLK_COUNT) begin
                count <= op.data[dma_desc_pkg::CNT_W-1:0];
            end
            if (wr && op.reg_addr == dma_regs_pkg::REG_BLK_RUN) begin
                run   <= op.data[0];
                state <= op.data[0] ? dma_desc_pkg::BLK_ISSUE : dma_desc_pkg::BLK_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            desc       <= next_desc;
            dma_offset <= dma_offset + cfg.dma_stride;
            ram_offset <= ram_offset + cfg.ram_stride;
        end else if (launch) begin
            desc <= single_desc;
        end
        if (wr && op.reg_addr == dma_regs_pkg::REG_BLK_DMA_OFFSET) begin
            dma_offset <= op.data;
        end
        if (wr && op.reg_addr == dma_regs_pkg::REG_BLK_RAM_OFFSET) begin
            ram_offset <= op.data[dma_desc_pkg::RAM_ADDR_W-1:0];
        end
    end

    assign blk.run        = run;
    assign blk.count      = count;
    assign blk.dma_offset = dma_offset;
    assign blk.ram_offset = ram_offset;

endmodule

/* rtl/dma_ctrl_top.sv */
// ###################################################################
// DMA descriptor controller top, decode, block engine and tracker
// ###################################################################

module dma_ctrl_top (
    input  logic                                clk,
    input  logic                                rst,
    input  dma_regs_pkg::reg_req_t              req,
    input  logic                                req_valid,
    output logic                                req_ready,
    output logic [dma_regs_pkg::REG_DATA_W-1:0] resp_data,
    output logic                                resp_valid,
    input  logic                                resp_ready,
    output dma_desc_pkg::dma_desc_t             desc,
    output logic                                desc_valid,
    input  logic                                desc_ready,
    input  dma_desc_pkg::dma_status_t           status,
    input  logic                                status_valid,
    output logic                                irq
);

    dma_regs_pkg::reg_op_t   op;
    dma_regs_pkg::blk_cfg_t  cfg;
    dma_desc_pkg::dma_desc_t single_desc;
    dma_regs_pkg::blk_view_t blk;
    dma_regs_pkg::trk_view_t trk;
    logic                    irq_en;

    dma_reg_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .resp_data   (resp_data),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .op          (op),
        .cfg         (cfg),
        .single_desc (single_desc),
        .irq_en      (irq_en),
        .blk         (blk),
        .trk         (trk)
    );

    dma_block_engine u_engine (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .cfg          (cfg),
        .single_desc  (single_desc),
        .active_count (trk.active),
        .desc         (desc),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .blk          (blk)
    );

    // counts transfers straight off the descriptor port
    dma_status_tracker u_tracker (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .irq_en       (irq_en),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .status       (status),
        .status_valid (status_valid),
        .trk          (trk),
        .irq          (irq)
    );

endmodule

/* rtl/dma_desc_pkg.sv */
// ###################################################################
// DMA side widths, descriptor and status structs, block engine states
// ###################################################################

package dma_desc_pkg;

    // host and RAM address widths
    localparam int DMA_ADDR_W = 32;
    localparam int RAM_ADDR_W = 16;

    localparam int LEN_W = 16;
    localparam int TAG_W = 8;
    localparam int ERR_W = 4;

    // block count and in-flight count
    localparam int CNT_W = 16;

    // descriptor to the DMA engine, 72 bits
    typedef struct packed {
        logic [DMA_ADDR_W-1:0] dma_addr;
        logic [RAM_ADDR_W-1:0] ram_addr;
        logic [LEN_W-1:0]      len;
        logic [TAG_W-1:0]      tag;
    } dma_desc_t;

    // completion from the DMA engine, 12 bits
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [ERR_W-1:0] error;
    } dma_status_t;

    typedef enum logic [1:0] {
        BLK_IDLE,
        BLK_ISSUE,
        BLK_DRAIN
    } blk_state_e;

endpackage

/* rtl/dma_reg_decode.sv */
// ###################################################################
// register bus handshake, address decode, config registers, read mux
// ###################################################################

module dma_reg_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  dma_regs_pkg::reg_req_t              req,
    input  logic                                req_valid,
    output logic                                req_ready,
    output logic [dma_regs_pkg::REG_DATA_W-1:0] resp_data,
    output logic                                resp_valid,
    input  logic                                resp_ready,
    output dma_regs_pkg::reg_op_t               op,
    output dma_regs_pkg::blk_cfg_t              cfg,
    output dma_desc_pkg::dma_desc_t             single_desc,
    output logic                                irq_en,
    input  dma_regs_pkg::blk_view_t             blk,
    input  dma_regs_pkg::trk_view_t             trk
);

    dma_regs_pkg::reg_addr_e             req_addr;
    logic                                accept;
    logic                                hit;
    logic                                wr;
    logic [dma_regs_pkg::REG_DATA_W-1:0] rdata;
    dma_desc_pkg::dma_desc_t             single_q;

    assign req_ready = !resp_valid;
    assign accept    = req_valid && req_ready;
    assign req_addr  = dma_regs_pkg::reg_addr_e'(req.addr);

    assign op.valid    = accept && hit;
    assign op.write    = req.write;
    assign op.reg_addr = req_addr;
    assign op.data     = req.wdata;
    assign wr          = op.valid && op.write;

    // address decode and read data, one case
    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (req_addr)
            dma_regs_pkg::REG_IRQ_EN:         rdata[0] = irq_en;
            dma_regs_pkg::REG_ACTIVE:         rdata[dma_desc_pkg::CNT_W-1:0] = trk.active;
            dma_regs_pkg::REG_DESC_DMA_ADDR:  rdata = single_q.dma_addr;
            dma_regs_pkg::REG_DESC_RAM_ADDR:  rdata[dma_desc_pkg::RAM_ADDR_W-1:0] = single_q.ram_addr;
            dma_regs_pkg::REG_DESC_LEN:       rdata[dma_desc_pkg::LEN_W-1:0] = single_q.len;
            dma_regs_pkg::REG_DESC_TAG:       rdata[dma_desc_pkg::TAG_W-1:0] = single_q.tag;
            dma_regs_pkg::REG_DESC_STATUS: begin
                rdata[dma_desc_pkg::TAG_W-1:0] = trk.status.tag;
                rdata[24 +: dma_desc_pkg::ERR_W] = trk.status.error;
                rdata[31] = trk.status_valid;
            end
            dma_regs_pkg::REG_BLK_RUN:        rdata[0] = blk.run;
            dma_regs_pkg::REG_BLK_LEN:        rdata[dma_desc_pkg::LEN_W-1:0] = cfg.len;
            dma_regs_pkg::REG_BLK_COUNT:      rdata[dma_desc_pkg::CNT_W-1:0] = blk.count;
            dma_regs_pkg::REG_BLK_DMA_BASE:   rdata = cfg.dma_base;
            dma_regs_pkg::REG_BLK_DMA_OFFSET: rdata = blk.dma_offset;
            dma_regs_pkg::REG_BLK_DMA_MASK:   rdata = cfg.dma_mask;
            dma_regs_pkg::REG_BLK_DMA_STRIDE: rdata = cfg.dma_stride;
            dma_regs_pkg::REG_BLK_RAM_BASE:   rdata[dma_desc_pkg::RAM_ADDR_W-1:0] = cfg.ram_base;
            dma_regs_pkg::REG_BLK_RAM_OFFSET: rdata[dma_desc_pkg::RAM_ADDR_W-1:0] = blk.ram_offset;
            dma_regs_pkg::REG_BLK_RAM_MASK:   rdata[dma_desc_pkg::RAM_ADDR_W-1:0] = cfg.ram_mask;
            dma_regs_pkg::REG_BLK_RAM_STRIDE: rdata[dma_desc_pkg::RAM_ADDR_W-1:0] = cfg.ram_stride;
            default:                          hit = 1'b0;
        endcase
    end

    // response held until resp_ready
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (accept) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_data <= req.write ? '0 : rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_en <= 1'b0;
        end else if (wr && op.reg_addr == dma_regs_pkg::REG_IRQ_EN) begin
            irq_en <= op.data[0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            case (op.reg_addr)
                dma_regs_pkg::REG_DESC_DMA_ADDR:  single_q.dma_addr <= op.data;
                dma_regs_pkg::REG_DESC_RAM_ADDR:
                    single_q.ram_addr <= op.data[dma_desc_pkg::RAM_ADDR_W-1:0];
                dma_regs_pkg::REG_DESC_LEN:       single_q.len <= op.data[dma_desc_pkg::LEN_W-1:0];
                dma_regs_pkg::REG_DESC_TAG:       single_q.tag <= op.data[dma_desc_pkg::TAG_W-1:0];
                dma_regs_pkg::REG_BLK_LEN:        cfg.len <= op.data[dma_desc_pkg::LEN_W-1:0];
                dma_regs_pkg::REG_BLK_DMA_BASE:   cfg.dma_base <= op.data;
                dma_regs_pkg::REG_BLK_DMA_MASK:   cfg.dma_mask <= op.data;
                dma_regs_pkg::REG_BLK_DMA_STRIDE: cfg.dma_stride <= op.data;
                dma_regs_pkg::REG_BLK_RAM_BASE:
                    cfg.ram_base <= op.data[dma_desc_pkg::RAM_ADDR_W-1:0];
                dma_regs_pkg::REG_BLK_RAM_MASK:
                    cfg.ram_mask <= op.data[dma_desc_pkg::RAM_ADDR_W-1:0];
                dma_regs_pkg::REG_BLK_RAM_STRIDE:
                    cfg.ram_stride <= op.data[dma_desc_pkg::RAM_ADDR_W-1:0];
                default: ;
            endcase
        end
    end

    // the tag write launches, so pass its data straight through
    always_comb begin
        single_desc = single_q;
        if (wr && op.reg_addr == dma_regs_pkg::REG_DESC_TAG) begin
            single_desc.tag = op.data[dma_desc_pkg::TAG_W-1:0];
        end
    end

endmodule

/* rtl/dma_regs_pkg.sv */
// ###################################################################
// register map and register bus structs, engine and tracker readback
// ###################################################################

package dma_regs_pkg;

    localparam int REG_ADDR_W = 16;
    localparam int REG_DATA_W = 32;

    // register map, also the opcode of an access
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_IRQ_EN         = 16'h0008,
        REG_ACTIVE         = 16'h0020,
        REG_DESC_DMA_ADDR  = 16'h0100,
        REG_DESC_RAM_ADDR  = 16'h0108,
        REG_DESC_LEN       = 16'h0110,
        REG_DESC_TAG       = 16'h0114,
        REG_DESC_STATUS    = 16'h0118,
        REG_BLK_RUN        = 16'h1000,
        REG_BLK_LEN        = 16'h1010,
        REG_BLK_COUNT      = 16'h1018,
        REG_BLK_DMA_BASE   = 16'h1080,
        REG_BLK_DMA_OFFSET = 16'h1088,
        REG_BLK_DMA_MASK   = 16'h1090,
        REG_BLK_DMA_STRIDE = 16'h1098,
        REG_BLK_RAM_BASE   = 16'h10c0,
        REG_BLK_RAM_OFFSET = 16'h10c8,
        REG_BLK_RAM_MASK   = 16'h10d0,
        REG_BLK_RAM_STRIDE = 16'h10d8
    } reg_addr_e;

    typedef struct packed {
        logic                  write;
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] wdata;
    } reg_req_t;

    // one-cycle pulse for a mapped access
    typedef struct packed {
        logic                  valid;
        logic                  write;
        reg_addr_e             reg_addr;
        logic [REG_DATA_W-1:0] data;
    } reg_op_t;

    typedef struct packed {
        logic [dma_desc_pkg::LEN_W-1:0]      len;
        logic [dma_desc_pkg::DMA_ADDR_W-1:0] dma_base;
        logic [dma_desc_pkg::DMA_ADDR_W-1:0] dma_mask;
        logic [dma_desc_pkg::DMA_ADDR_W-1:0] dma_stride;
        logic [dma_desc_pkg::RAM_ADDR_W-1:0] ram_base;
        logic [dma_desc_pkg::RAM_ADDR_W-1:0] ram_mask;
        logic [dma_desc_pkg::RAM_ADDR_W-1:0] ram_stride;
    } blk_cfg_t;

    typedef struct packed {
        logic                                run;
        logic [dma_desc_pkg::CNT_W-1:0]      count;
        logic [dma_desc_pkg::DMA_ADDR_W-1:0] dma_offset;
        logic [dma_desc_pkg::RAM_ADDR_W-1:0] ram_offset;
    } blk_view_t;

    typedef struct packed {
        dma_desc_pkg::dma_status_t      status;
        logic                           status_valid;
        logic [dma_desc_pkg::CNT_W-1:0] active;
    } trk_view_t;

endpackage

/* rtl/dma_status_tracker.sv */
// ###################################################################
// status capture, in-flight descriptor count, completion interrupt
// ###################################################################

module dma_status_tracker (
    input  logic                      clk,
    input  logic                      rst,
    input  dma_regs_pkg::reg_op_t     op,
    input  logic                      irq_en,
    input  logic                      desc_valid,
    input  logic                      desc_ready,
    input  dma_desc_pkg::dma_status_t status,
    input  logic                      status_valid,
    output dma_regs_pkg::trk_view_t   trk,
    output logic                      irq
);

    logic                           status_rd;
    logic                           xfer;
    logic                           held_valid;
    logic [dma_desc_pkg::CNT_W-1:0] active;
    dma_desc_pkg::dma_status_t      held;

    assign xfer      = desc_valid && desc_ready;
    assign status_rd = op.valid && !op.write
                       && op.reg_addr == dma_regs_pkg::REG_DESC_STATUS;

    always_ff @(posedge clk) begin
        if (status_valid) begin
            held <= status;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
            active     <= '0;
        end else begin
            // a new status wins over a read clear
            if (status_valid) begin
                held_valid <= 1'b1;
            end else if (status_rd) begin
                held_valid <= 1'b0;
            end
            case ({xfer, status_valid})
                2'b10:   active <= active + 1'b1;
                2'b01:   active <= active - 1'b1;
                default: ;
            endcase
        end
    end

    assign trk.status       = held;
    assign trk.status_valid = held_valid;
    assign trk.active       = active;

    assign irq = status_valid && irq_en;

endmodule

/* sim.f */
rtl/dma_desc_pkg.sv
rtl/dma_regs_pkg.sv
rtl/dma_reg_decode.sv
rtl/dma_block_engine.sv
rtl/dma_status_tracker.sv
rtl/dma_ctrl_top.sv
dv/dma_ctrl_checker.sv
dv/dma_ctrl_sva.sv
dv/dma_ctrl_tb.sv
